//--- capture/pixel_capture.sv
module pixel_capture (
  input logic clk_pixel,
  input logic sys_rst,
  input qr_pkg::cam_pix_t cam,
  input qr_pkg::thresh_t thresh,
  input logic freeze,
  output qr_pkg::ram_wr_t wr
);

  // channels expanded to 8 bits
  logic [7:0] red8;
  logic [7:0] green8;
  logic [7:0] blue8;
  logic [10:0] luma_sum; // 2r + 5g + b, max 2004
  logic [7:0] luma;
  logic bin_q; // stage 1 binarized pixel
  logic valid_q;
  logic in_win_q;
  qr_pkg::addr_t addr_q;

  assign red8 = {cam.pixel[15:11], 3'b000};
  assign green8 = {cam.pixel[10:5], 2'b00};
  assign blue8 = {cam.pixel[4:0], 3'b000};
  assign luma_sum = {2'b00, red8, 1'b0} + 11'(green8) * 11'd5 + {3'b000, blue8};
  assign luma = luma_sum[10:3]; // divide by 8

  // first stage thresholds the beat and places it in the window
  always_ff @(posedge clk_pixel) begin
    bin_q <= luma > thresh; // strictly above counts as white
    in_win_q <= (cam.hcount < qr_pkg::store_w) && (cam.vcount < qr_pkg::store_h);
    addr_q <= qr_pkg::addr_t'(cam.hcount + qr_pkg::store_w * cam.vcount);
    if (sys_rst) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= cam.valid;
    end
  end

  // second stage writes the buffer unless frozen or outside the window
  always_ff @(posedge clk_pixel) begin
    wr.addr <= addr_q;
    wr.data <= bin_q;
    if (sys_rst) begin
      wr.we <= 1'b0;
    end else begin
      wr.we <= valid_q && in_win_q && !freeze;
    end
  end

  // every write stems from an in-window beat two cycles back and never wraps the buffer
  a_wr_in_range: assert property (@(posedge clk_pixel) disable iff (sys_rst)
    wr.we |-> ($past(cam.hcount, 2) < qr_pkg::store_w)
      && ($past(cam.vcount, 2) < qr_pkg::store_h));

endmodule

//--- clean/clean_pass.sv
module clean_pass (
  input logic clk_pixel,
  input logic sys_rst,
  input qr_pkg::scan_phase_t phase,
  output qr_pkg::addr_t rd_addr,
  input logic rd_data, // frame bit for the address issued last cycle
  output qr_pkg::ram_wr_t wr,
  output logic done
);

  // counts one past the last address, that extra slot flushes the final pixel
  logic [$clog2(qr_pkg::ram_depth):0] rd_cnt;
  logic [$clog2(qr_pkg::ram_depth):0] arr_idx; // index of the bit now on rd_data
  logic arr_valid;
  logic sweep_on;
  logic row_start; // arriving bit opens a new row, or is the flush slot
  logic left_bit; // window, two pixels back
  logic mid_bit; // window, one pixel back, the one being emitted
  logic right_bit;
  logic maj_bit;

  // sweep once, the counter parks past the end and never rearms
  assign sweep_on = (phase == qr_pkg::phase_cleaning) && (rd_cnt <= qr_pkg::ram_depth);
  assign rd_addr = qr_pkg::addr_t'(rd_cnt);

  assign row_start = (arr_idx % qr_pkg::store_w) == 0;
  assign right_bit = row_start ? 1'b0 : rd_data; // missing right neighbour reads 0
  assign maj_bit = (left_bit & mid_bit) | (left_bit & right_bit) | (mid_bit & right_bit);

  always_ff @(posedge clk_pixel) begin
    arr_idx <= rd_cnt;
    if (sys_rst) begin
      rd_cnt <= '0;
      arr_valid <= 1'b0;
    end else begin
      arr_valid <= sweep_on;
      if (sweep_on) begin
        rd_cnt <= rd_cnt + 1'b1;
      end
    end
  end

  // slide the window along the row
  always_ff @(posedge clk_pixel) begin
    if (arr_valid) begin
      left_bit <= row_start ? 1'b0 : mid_bit; // left edge of a row reads 0
      mid_bit <= rd_data;
    end
  end

  // emit the pixel one behind the read
  always_ff @(posedge clk_pixel) begin
    wr.addr <= qr_pkg::addr_t'(arr_idx - 1'b1);
    wr.data <= maj_bit;
    if (sys_rst) begin
      wr.we <= 1'b0;
      done <= 1'b0;
    end else begin
      wr.we <= arr_valid && (arr_idx != 0); // index 0 has nothing behind it yet
      done <= wr.we && (wr.addr == qr_pkg::addr_t'(qr_pkg::ram_depth - 1));
    end
  end

  // the sequencer leaves cleaning only after seeing done
  a_done_in_clean: assert property (@(posedge clk_pixel) disable iff (sys_rst)
    done |-> (phase == qr_pkg::phase_cleaning));

endmodule

//--- common/qr_pkg.sv
package qr_pkg;

  // stored window, the corner of the camera raster that gets kept
  localparam int store_w = 32;
  localparam int store_h = 32;
  localparam int ram_depth = store_w * store_h; // one bit per stored pixel

  typedef logic [5:0] coord_t; // camera or screen coordinate, rasters up to 64
  typedef logic [$clog2(ram_depth)-1:0] addr_t; // column + store_w * row
  typedef logic [15:0] rgb565_t; // r[15:11] g[10:5] b[4:0]
  typedef logic [7:0] thresh_t; // luma threshold, 0..255
  typedef logic [1:0] view_t; // 0 frame, 1 cleaned, 2 and 3 black

  // scan phases, only ever moving forward until reset
  typedef enum logic [1:0] {
    phase_streaming, // capture runs, view 0 shows the live frame
    phase_cleaning,  // majority pass owns the frame buffer read port
    phase_done       // cleaned buffer ready
  } scan_phase_t;

  // one camera beat, no back-pressure
  typedef struct packed {
    logic valid;
    coord_t hcount;
    coord_t vcount;
    rgb565_t pixel;
  } cam_pix_t;

  // one display lookup, answered two cycles later
  typedef struct packed {
    logic valid;
    coord_t x;
    coord_t y;
  } disp_req_t;

  // one write into a one-bit buffer
  typedef struct packed {
    logic we;
    addr_t addr;
    logic data;
  } ram_wr_t;

endpackage

//--- run.sh
#!/bin/sh
# build and run the qr image path testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module qr_tb -o qr_tb_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/qr_tb_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Errors found" sim.log; then
  exit 1
fi
exit 0

//--- src/bit_ram.sv
module bit_ram (
  input logic clk_pixel,
  input qr_pkg::ram_wr_t wr,
  input qr_pkg::addr_t rd_addr,
  output logic rd_data
);

  logic mem [qr_pkg::ram_depth]; // one bit per window pixel

  // write port
  always_ff @(posedge clk_pixel) begin
    if (wr.we) begin
      mem[wr.addr] <= wr.data;
    end
  end

  // registered read, data one cycle after the address
  always_ff @(posedge clk_pixel) begin
    rd_data <= mem[rd_addr];
  end

endmodule

//--- src/display_reader.sv
module display_reader (
  input logic clk_pixel,
  input logic sys_rst,
  input qr_pkg::disp_req_t req,
  input qr_pkg::view_t view,
  input qr_pkg::scan_phase_t phase,
  input qr_pkg::addr_t clean_addr,
  output qr_pkg::addr_t frame_addr,
  input logic frame_bit,
  output qr_pkg::addr_t cleaned_addr,
  input logic cleaned_bit,
  output logic pix_valid,
  output logic pix
);

  qr_pkg::addr_t req_addr; // screen maps straight onto the window
  logic req_in_win;
  logic cleaning;
  logic valid_q; // stage 1, buffers are reading
  logic in_win_q;
  logic blank_q; // asked while cleaning ran
  qr_pkg::view_t view_q;

  assign cleaning = (phase == qr_pkg::phase_cleaning);
  assign req_in_win = (req.x < qr_pkg::store_w) && (req.y < qr_pkg::store_h);
  assign req_addr = qr_pkg::addr_t'(req.x + qr_pkg::store_w * req.y);

  // cleaning pass owns the frame read port while it runs
  assign frame_addr = cleaning ? clean_addr : req_addr;
  assign cleaned_addr = req_addr;

  always_ff @(posedge clk_pixel) begin
    in_win_q <= req_in_win;
    blank_q <= cleaning;
    view_q <= view;
    if (sys_rst) begin
      valid_q <= 1'b0;
      pix_valid <= 1'b0;
      pix <= 1'b0;
    end else begin
      valid_q <= req.valid;
      pix_valid <= valid_q;
      // stage 2: pick the view, black outside the window or for views 2 and 3
      case (view_q)
        2'd0: pix <= in_win_q && !blank_q && frame_bit;
        2'd1: pix <= in_win_q && !blank_q && cleaned_bit;
        default: pix <= 1'b0;
      endcase
    end
  end

endmodule

//--- src/qr_top.sv
module qr_top (
  input logic clk_pixel,
  input logic sys_rst,
  input qr_pkg::cam_pix_t cam, // camera beat, taken every cycle
  input qr_pkg::thresh_t thresh,
  input logic freeze, // stops capture into the frame buffer
  input logic start, // with freeze, kicks off the cleaning pass
  input qr_pkg::view_t view,
  input qr_pkg::disp_req_t req,
  output logic pix_valid,
  output logic pix,
  output qr_pkg::scan_phase_t phase
);

  qr_pkg::ram_wr_t cap_wr; // capture into frame buffer
  qr_pkg::ram_wr_t clean_wr; // cleaning pass into cleaned buffer
  qr_pkg::addr_t clean_addr; // read address from the cleaning pass
  qr_pkg::addr_t frame_addr;
  qr_pkg::addr_t cleaned_addr;
  logic frame_bit; // shared by display and cleaning
  logic cleaned_bit;
  logic clean_done;

  pixel_capture i_pixel_capture (
    .clk_pixel(clk_pixel),
    .sys_rst(sys_rst),
    .cam(cam),
    .thresh(thresh),
    .freeze(freeze),
    .wr(cap_wr)
  );

  // binarized camera frame
  bit_ram i_frame_ram (
    .clk_pixel(clk_pixel),
    .wr(cap_wr),
    .rd_addr(frame_addr),
    .rd_data(frame_bit)
  );

  clean_pass i_clean_pass (
    .clk_pixel(clk_pixel),
    .sys_rst(sys_rst),
    .phase(phase),
    .rd_addr(clean_addr),
    .rd_data(frame_bit), // arrives one cycle after clean_addr
    .wr(clean_wr),
    .done(clean_done)
  );

  // majority-filtered copy
  bit_ram i_clean_ram (
    .clk_pixel(clk_pixel),
    .wr(clean_wr),
    .rd_addr(cleaned_addr),
    .rd_data(cleaned_bit)
  );

  scan_sequencer i_scan_sequencer (
    .clk_pixel(clk_pixel),
    .sys_rst(sys_rst),
    .freeze(freeze),
    .start(start),
    .done(clean_done),
    .phase(phase)
  );

  display_reader i_display_reader (
    .clk_pixel(clk_pixel),
    .sys_rst(sys_rst),
    .req(req),
    .view(view),
    .phase(phase),
    .clean_addr(clean_addr),
    .frame_addr(frame_addr),
    .frame_bit(frame_bit),
    .cleaned_addr(cleaned_addr),
    .cleaned_bit(cleaned_bit),
    .pix_valid(pix_valid),
    .pix(pix)
  );

endmodule

//--- src/scan_sequencer.sv
module scan_sequencer (
  input logic clk_pixel,
  input logic sys_rst,
  input logic freeze,
  input logic start,
  input logic done, // one-cycle pulse from the cleaning pass
  output qr_pkg::scan_phase_t phase
);

  always_ff @(posedge clk_pixel) begin
    if (sys_rst) begin
      phase <= qr_pkg::phase_streaming;
    end else begin
      case (phase)
        qr_pkg::phase_streaming: begin
          // decode only on a frozen picture
          if (freeze && start) begin
            phase <= qr_pkg::phase_cleaning;
          end
        end
        qr_pkg::phase_cleaning: begin
          if (done) begin
            phase <= qr_pkg::phase_done;
          end
        end
        qr_pkg::phase_done: begin
          phase <= qr_pkg::phase_done; // held until reset
        end
        default: begin
          phase <= qr_pkg::phase_streaming;
        end
      endcase
    end
  end

  // phase only ever steps forward between resets
  a_forward_only: assert property (@(posedge clk_pixel) disable iff (sys_rst)
    1'b1 |=> (phase >= $past(phase)));

endmodule

//--- tb.f
+incdir+verification
common/qr_pkg.sv
capture/pixel_capture.sv
src/bit_ram.sv
clean/clean_pass.sv
src/scan_sequencer.sv
src/display_reader.sv
src/qr_top.sv
verification/qr_tb.sv

//--- verification/qr_tb_ref.svh
`ifndef QR_TB_REF_SVH
`define QR_TB_REF_SVH

// reference model pieces, included inside qr_tb

// rgb565 pixel against the luma threshold, white when strictly above
function automatic logic binarize(input logic [15:0] px, input logic [7:0] th);
  int r;
  int g;
  int b;
  int luma;
  r = int'(px[15:11]) << 3; // red and blue to 8 bits
  g = int'(px[10:5]) << 2;
  b = int'(px[4:0]) << 3;
  luma = (2 * r + 5 * g + b) / 8;
  return luma > int'(th);
endfunction

// two of three
function automatic logic majority3(input logic l, input logic m, input logic r);
  return (l && m) || (l && r) || (m && r);
endfunction

// galois lfsr, x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
  if (s[0]) begin
    return (s >> 1) ^ 32'h8020_0003;
  end
  return s >> 1;
endfunction

// one compare, counted, mismatch reported on the spot
task automatic check_value(input string sig, input logic [31:0] got,
                           input logic [31:0] exp);
  checks++;
  if (got !== exp) begin
    errors++;
    $display("mismatch at %0t: %s got %0h expected %0h", $time, sig, got, exp);
  end
endtask

`endif

//--- verification/qr_tb.sv
module qr_tb;

  localparam int clk_period = 40;
  localparam int raster_cycles = 40 * 40; // full camera raster
  localparam int read_cycles = qr_pkg::ram_depth + 16; // one window readback
  localparam int clean_cycles = qr_pkg::ram_depth + 64;
  localparam int watchdog_cycles = 16 + 2 * raster_cycles + 4 * read_cycles
                                   + clean_cycles + 2000; // margin for the short tests

  logic clk_pixel;
  logic sys_rst;
  qr_pkg::cam_pix_t cam;
  qr_pkg::thresh_t thresh;
  logic freeze;
  logic start;
  qr_pkg::view_t view;
  qr_pkg::disp_req_t req;
  logic pix_valid;
  logic pix;
  qr_pkg::scan_phase_t phase;

  int errors;
  int checks;
  int errs_at_start;
  int checks_at_start;
  logic [31:0] lfsr_state;
  logic frame_model [qr_pkg::ram_depth]; // expected frame buffer
  logic clean_model [qr_pkg::ram_depth]; // expected cleaned buffer
  logic exp_q [$]; // expected bit per request in flight

  `include "qr_tb_ref.svh"

  qr_top i_dut (
    .clk_pixel(clk_pixel),
    .sys_rst(sys_rst),
    .cam(cam),
    .thresh(thresh),
    .freeze(freeze),
    .start(start),
    .view(view),
    .req(req),
    .pix_valid(pix_valid),
    .pix(pix),
    .phase(phase)
  );

  // n random bits with the lfsr stepped once per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      val[i] = lfsr_state[0];
    end
    return val;
  endfunction

  task automatic drive_req(input qr_pkg::coord_t x, input qr_pkg::coord_t y,
                           input qr_pkg::view_t v, input logic e);
    @(posedge clk_pixel);
    #5;
    req = '{valid: 1'b1, x: x, y: y};
    view = v;
    exp_q.push_back(e); // answered two cycles on
  endtask

  task automatic end_reqs();
    @(posedge clk_pixel);
    #5;
    req.valid = 1'b0;
  endtask

  // all responses back within a few cycles of the last request
  task automatic wait_responses();
    int n;
    n = 0;
    while (exp_q.size() != 0 && n < 8) begin
      @(posedge clk_pixel);
      #5;
      n++;
    end
    if (exp_q.size() != 0) begin
      errors++;
      $display("%0d display responses never arrived", exp_q.size());
      exp_q.delete();
    end
  endtask

  // full 40 by 40 raster where the model follows in-window beats only when asked
  task automatic send_raster(input logic track);
    logic [15:0] px;
    for (int v = 0; v < 40; v++) begin
      for (int h = 0; h < 40; h++) begin
        px = 16'(rand_bits(16));
        @(posedge clk_pixel);
        #5;
        cam = '{valid: 1'b1, hcount: qr_pkg::coord_t'(h), vcount: qr_pkg::coord_t'(v),
                pixel: px};
        if (track && h < qr_pkg::store_w && v < qr_pkg::store_h) begin
          frame_model[h + qr_pkg::store_w * v] = binarize(px, thresh);
        end
      end
    end
    @(posedge clk_pixel);
    #5;
    cam.valid = 1'b0;
    repeat (4) @(posedge clk_pixel); // last write lands two edges later
  endtask

  // every window pixel of one view in back to back requests
  task automatic read_view(input qr_pkg::view_t v);
    logic e;
    for (int i = 0; i < qr_pkg::ram_depth; i++) begin
      e = (v == 2'd0) ? frame_model[i] : clean_model[i];
      drive_req(qr_pkg::coord_t'(i % qr_pkg::store_w), qr_pkg::coord_t'(i / qr_pkg::store_w),
                v, e);
    end
    end_reqs();
    wait_responses();
  endtask

  task automatic start_test();
    errs_at_start = errors;
    checks_at_start = checks;
  endtask

  task automatic report_test(input int num, input string name);
    $display("test %0d %s finished, %0d checks, %0d errors", num, name,
             checks - checks_at_start, errors - errs_at_start);
  endtask

  initial begin
    clk_pixel = 1'b0;
    forever #(clk_period / 2) clk_pixel = ~clk_pixel;
  end

  // responses sampled mid cycle where outputs are settled
  initial begin
    forever begin
      @(negedge clk_pixel);
      if (pix_valid) begin
        if (exp_q.size() == 0) begin
          errors++;
          $display("pix_valid came at %0t with no request outstanding", $time);
        end else begin
          check_value("pix", 32'(pix), 32'(exp_q.pop_front()));
        end
      end
    end
  end

  initial begin
    #(watchdog_cycles * clk_period);
    $display("watchdog expired after %0d cycles, the run did not finish", watchdog_cycles);
    $display("checks %0d, errors %0d", checks, errors + 1);
    $display("Errors found");
    $finish;
  end

  initial begin
    int n;
    logic l;
    logic r;
    sys_rst = 1'b1;
    cam = '0;
    thresh = '0;
    freeze = 1'b0;
    start = 1'b0;
    view = '0;
    req = '0;
    errors = 0;
    checks = 0;
    lfsr_state = 32'h253a_0c53;
    repeat (16) @(posedge clk_pixel);
    #5;
    sys_rst = 1'b0;

    // 1 idle after reset
    start_test();
    check_value("phase", 32'(phase), 32'(qr_pkg::phase_streaming));
    repeat (8) begin
      @(posedge clk_pixel);
      #5;
      check_value("pix_valid", 32'(pix_valid), 32'd0);
    end
    report_test(1, "reset");

    // 2 capture a frame and read it back in view 0
    start_test();
    thresh = qr_pkg::thresh_t'(rand_bits(8));
    send_raster(1'b1);
    read_view(2'd0);
    report_test(2, "capture");

    // 3 out of window and the black views
    start_test();
    for (int i = 0; i < 32; i++) begin
      drive_req(qr_pkg::coord_t'(32 + rand_bits(5)), qr_pkg::coord_t'(rand_bits(6)),
                qr_pkg::view_t'(rand_bits(1)), 1'b0); // x past the window
    end
    for (int i = 0; i < 32; i++) begin
      drive_req(qr_pkg::coord_t'(rand_bits(6)), qr_pkg::coord_t'(32 + rand_bits(5)),
                qr_pkg::view_t'(rand_bits(1)), 1'b0); // y past the window
    end
    for (int i = 0; i < 64; i++) begin
      drive_req(qr_pkg::coord_t'(rand_bits(6)), qr_pkg::coord_t'(rand_bits(6)),
                qr_pkg::view_t'(2 + rand_bits(1)), 1'b0);
    end
    end_reqs();
    wait_responses();
    report_test(3, "black");

    // 4 frozen capture keeps the first frame
    start_test();
    freeze = 1'b1;
    repeat (3) @(posedge clk_pixel);
    #5;
    thresh = qr_pkg::thresh_t'(rand_bits(8));
    send_raster(1'b0);
    read_view(2'd0);
    report_test(4, "freeze");

    // 5 cleaning pass
    start_test();
    for (int i = 0; i < qr_pkg::ram_depth; i++) begin
      l = (i % qr_pkg::store_w != 0) ? frame_model[i - 1] : 1'b0; // row edges read 0
      r = (i % qr_pkg::store_w != qr_pkg::store_w - 1) ? frame_model[i + 1] : 1'b0;
      clean_model[i] = majority3(l, frame_model[i], r);
    end
    start = 1'b1;
    n = 0;
    while (phase != qr_pkg::phase_cleaning && n < 4) begin
      @(posedge clk_pixel);
      #5;
      n++;
    end
    start = 1'b0;
    if (phase != qr_pkg::phase_cleaning) begin
      errors++;
      $display("phase did not enter cleaning after start");
    end else begin
      for (int i = 0; i < 16; i++) begin
        drive_req(qr_pkg::coord_t'(rand_bits(5)), qr_pkg::coord_t'(rand_bits(5)),
                  qr_pkg::view_t'(rand_bits(1)), 1'b0); // blanked while cleaning
      end
      end_reqs();
      wait_responses();
    end
    n = 0;
    while (phase != qr_pkg::phase_done && n < clean_cycles) begin
      @(posedge clk_pixel);
      #5;
      n++;
    end
    if (phase != qr_pkg::phase_done) begin
      errors++;
      $display("phase did not reach done within %0d cycles", clean_cycles);
    end else begin
      read_view(2'd1);
      read_view(2'd0); // frame untouched by cleaning
    end
    report_test(5, "cleaning");

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule
